// ==== hdl/dataFilter.sv ====
// Sample to bin mapping for the current pass
// Coarse pass keeps the top bits, fine pass takes the offset inside the
// pixel's window and drops anything outside it
`timescale 1ns/1ps
`default_nettype none

module dataFilter (
    input  logic                            sampleValid,
    input  logic [sifhPkg::SAMPLE_W-1:0]    sample,
    input  sifhPkg::seqState_t              seq,
    input  sifhPkg::windowSet_t             windows,
    output sifhPkg::binReq_t                req
);

    logic [sifhPkg::SAMPLE_W-1:0] lower;       // Window base of this pixel
    logic [sifhPkg::SAMPLE_W-1:0] offset;
    logic                         inWindow;

    always_comb begin
        lower  = windows.lower[seq.pixel];
        offset = sample - lower;
        // Above the base and less than one histogram wide
        inWindow = (sample >= lower) && (offset[sifhPkg::SAMPLE_W-1:sifhPkg::BIN_W] == '0);

        req.pixel      = seq.pixel;
        req.lastOfPass = sampleValid && seq.lastOfPass;  // Passes even on reject
        if (seq.fine) begin
            req.bin   = offset[sifhPkg::BIN_W-1:0];
            req.valid = sampleValid && inWindow;         // Outliers dropped
        end else begin
            req.bin   = sample[sifhPkg::SAMPLE_W-1 -: sifhPkg::BIN_W];
            req.valid = sampleValid;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/frameSequencer.sv ====
// Stream position tracker
// Counts samples, pixels and acquisitions on each strobe and flips the pass
// Outputs describe the strobe of the current cycle
`timescale 1ns/1ps
`default_nettype none

module frameSequencer (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                sampleValid,
    output sifhPkg::seqState_t  seq
);

    logic [sifhPkg::DATA_W-1:0]  dataCnt;     // Sample within pixel
    logic [sifhPkg::PIXEL_W-1:0] pixelCnt;
    logic [sifhPkg::ACQ_W-1:0]   acqCnt;
    logic                        finePass;
    logic                        lastData;
    logic                        lastPixel;
    logic                        lastAcq;

    assign lastData  = (dataCnt == sifhPkg::DATA_LAST);
    assign lastPixel = (pixelCnt == sifhPkg::PIXEL_LAST);
    assign lastAcq   = (acqCnt == sifhPkg::ACQ_LAST);

    assign seq.fine       = finePass;
    assign seq.pixel      = pixelCnt;
    assign seq.lastOfPass = lastData && lastPixel && lastAcq;  // Not gated by strobe

    // **************************************************
    // Nested counters, stream order acq > pixel > sample
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            dataCnt  <= '0;
            pixelCnt <= '0;
            acqCnt   <= '0;
            finePass <= 1'b0;                   // Start in coarse pass
        end else if (sampleValid) begin
            dataCnt <= dataCnt + 1'b1;          // Wraps at DATA_NUM
            if (lastData) begin
                pixelCnt <= pixelCnt + 1'b1;
                if (lastPixel) begin
                    acqCnt <= acqCnt + 1'b1;
                    if (lastAcq) begin
                        finePass <= ~finePass;  // Pass complete
                    end
                end
            end
        end
    end

    // Pass only flips as all counters wrap to the start of a frame
    passFlipAtWrap: assert property (@(posedge clk) disable iff (!combin_res)
        (finePass != $past(finePass)) |->
            (dataCnt == '0 && pixelCnt == '0 && acqCnt == '0));

endmodule

`default_nettype wire

// ==== hdl/histUpdater.sv ====
// Per-pixel histograms with lazy clear and running peak search
// Counts are written at the strobe edge, the maximum one edge later
// At pass end the peaks are frozen for windowCalc and passDone pulses
`timescale 1ns/1ps
`default_nettype none

module histUpdater (
    input  logic                clk,
    input  logic                combin_res,
    input  sifhPkg::binReq_t    req,
    input  logic                fine,
    output sifhPkg::peakSet_t   peaks,
    output logic                passDone,
    output logic                donePassFine
);

    // **************************************************
    // Bin storage
    logic [sifhPkg::COUNT_W-1:0]            binMem [sifhPkg::HIST_DEPTH];
    logic [sifhPkg::HIST_DEPTH-1:0]         binValid;   // 0 means bin reads as empty
    logic [sifhPkg::PIXEL_W+sifhPkg::BIN_W-1:0] addr;
    logic [sifhPkg::COUNT_W-1:0]            curCount;
    logic [sifhPkg::COUNT_W-1:0]            newCount;

    // Stage into the maximum update
    logic                                   stgValid;
    logic                                   stgLast;
    logic                                   stgFine;
    logic [sifhPkg::PIXEL_W-1:0]            stgPixel;
    logic [sifhPkg::BIN_W-1:0]              stgBin;
    logic [sifhPkg::COUNT_W-1:0]            stgCount;

    // Running peak search
    logic [sifhPkg::PIXEL_NUM-1:0][sifhPkg::COUNT_W-1:0] runMax;
    logic [sifhPkg::PIXEL_NUM-1:0][sifhPkg::COUNT_W-1:0] nextMax;
    sifhPkg::peakSet_t                      runPeak;
    sifhPkg::peakSet_t                      nextPeak;
    sifhPkg::peakSet_t                      peakHold;   // Peaks of the last finished pass
    logic                                   doneDly;
    logic                                   doneDlyFine;

    assign addr     = {req.pixel, req.bin};
    assign curCount = binValid[addr] ? binMem[addr] : '0;
    assign newCount = curCount + 1'b1;      // Invalid bin is written as 1

    always_ff @(posedge clk) begin
        if (req.valid) begin
            binMem[addr] <= newCount;
        end
    end

    // Last request of a pass wipes the valid bits, so the next strobe starts clean
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (req.lastOfPass) begin
            binValid <= '0;
        end else if (req.valid) begin
            binValid[addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            stgValid <= 1'b0;
            stgLast  <= 1'b0;
            stgFine  <= 1'b0;
        end else begin
            stgValid <= req.valid;
            stgLast  <= req.lastOfPass;
            stgFine  <= fine;               // Pass of the strobe, before the flip
        end
    end

    always_ff @(posedge clk) begin
        stgPixel <= req.pixel;
        stgBin   <= req.bin;
        stgCount <= newCount;
    end

    // **************************************************
    // Strictly greater, so the first bin to reach the top stays
    always_comb begin
        nextMax  = runMax;
        nextPeak = runPeak;
        if (stgValid && (stgCount > runMax[stgPixel])) begin
            nextMax[stgPixel]      = stgCount;
            nextPeak.bin[stgPixel] = stgBin;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            runMax       <= '0;
            runPeak      <= '0;
            peakHold     <= '0;
            doneDly      <= 1'b0;
            doneDlyFine  <= 1'b0;
            passDone     <= 1'b0;
            donePassFine <= 1'b0;
        end else begin
            doneDly      <= stgLast;
            doneDlyFine  <= stgFine;
            passDone     <= doneDly;        // 2 cycles after the final strobe edge
            donePassFine <= doneDlyFine;
            if (stgLast) begin
                peakHold <= nextPeak;       // Freeze, then restart at bin 0
                runMax   <= '0;
                runPeak  <= '0;
            end else begin
                runMax   <= nextMax;
                runPeak  <= nextPeak;
            end
        end
    end

    // Forward the final peaks while the last update is in flight
    assign peaks = stgLast ? nextPeak : peakHold;

    countNoOverflow: assert property (@(posedge clk) disable iff (!combin_res)
        req.valid |-> (curCount != '1));

    passDoneSingle: assert property (@(posedge clk) disable iff (!combin_res)
        passDone |=> !passDone);

endmodule

`default_nettype wire

// ==== hdl/sifhPkg.sv ====
// Shared sizes, window constants and bus structs for the SiFH peak finder
// Every RTL file refers to these by scoped name
`default_nettype none

package sifhPkg;

    // **************************************************
    // Frame geometry
    localparam int SAMPLE_W  = 8;               // Time sample width
    localparam int BIN_W     = 4;               // 16 bins per histogram
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_W   = 2;
    localparam int DATA_NUM  = 4;               // Samples per pixel per acquisition
    localparam int ACQ_NUM   = 2;               // Acquisitions per frame, 32 samples per pass
    localparam int DATA_W    = $clog2(DATA_NUM);
    localparam int ACQ_W     = $clog2(ACQ_NUM);
    localparam int COUNT_W   = 4;               // Max count is 8
    localparam int BIN_NUM   = 1 << BIN_W;
    localparam int HIST_DEPTH = PIXEL_NUM * BIN_NUM;

    // Last counter values, sized for direct compares
    localparam logic [DATA_W-1:0]  DATA_LAST  = DATA_W'(DATA_NUM - 1);
    localparam logic [PIXEL_W-1:0] PIXEL_LAST = PIXEL_W'(PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0]   ACQ_LAST   = ACQ_W'(ACQ_NUM - 1);

    // Window rule
    localparam logic [SAMPLE_W-1:0] HALF_WIN      = 8'd8;
    localparam logic [SAMPLE_W-1:0] WIN_MAX_LOWER = 8'd240;   // Keeps lower+15 within 255

    // **************************************************
    // Buses
    typedef struct packed {
        logic               valid;
        logic [PIXEL_W-1:0] pixel;
        logic [BIN_W-1:0]   bin;
        logic               lastOfPass;     // Final sample of a pass, even when rejected
    } binReq_t;

    typedef struct packed {
        logic               fine;           // 0 coarse, 1 fine
        logic [PIXEL_W-1:0] pixel;
        logic               lastOfPass;
    } seqState_t;

    typedef struct packed {
        logic [PIXEL_NUM-1:0][BIN_W-1:0] bin;
    } peakSet_t;

    typedef struct packed {
        logic [PIXEL_NUM-1:0][SAMPLE_W-1:0] lower;
    } windowSet_t;

    typedef struct packed {
        logic [PIXEL_NUM-1:0][SAMPLE_W-1:0] peakTime;
    } resultSet_t;

endpackage

`default_nettype wire

// ==== hdl/sifhTop.sv ====
// Top of the two-pass histogram peak finder
// Feed one sample per strobe in stream order, each frame twice
// resultValid pulses once per frame with the per-pixel peak times
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  logic                            clk,
    input  logic                            combin_res,
    input  logic                            sampleValid,
    input  logic [sifhPkg::SAMPLE_W-1:0]    sample,
    output sifhPkg::resultSet_t             results,
    output logic                            resultValid
);

    sifhPkg::seqState_t     seq;
    sifhPkg::binReq_t       req;
    sifhPkg::windowSet_t    windows;
    sifhPkg::peakSet_t      peaks;
    logic                   passDone;
    logic                   donePassFine;

    frameSequencer u_frameSequencer (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .seq         (seq)
    );

    dataFilter u_dataFilter (
        .sampleValid (sampleValid),
        .sample      (sample),
        .seq         (seq),
        .windows     (windows),
        .req         (req)
    );

    histUpdater u_histUpdater (
        .clk          (clk),
        .combin_res   (combin_res),
        .req          (req),
        .fine         (seq.fine),
        .peaks        (peaks),
        .passDone     (passDone),
        .donePassFine (donePassFine)
    );

    windowCalc u_windowCalc (
        .clk          (clk),
        .combin_res   (combin_res),
        .peaks        (peaks),
        .passDone     (passDone),
        .donePassFine (donePassFine),
        .windows      (windows),
        .results      (results),
        .resultValid  (resultValid)
    );

endmodule

`default_nettype wire

// ==== hdl/windowCalc.sv ====
// Window placement and final result
// Coarse peaks give a 16 wide window per pixel, clamped at both ends
// Fine peaks plus the window base give the reported times
`timescale 1ns/1ps
`default_nettype none

module windowCalc (
    input  logic                    clk,
    input  logic                    combin_res,
    input  sifhPkg::peakSet_t       peaks,
    input  logic                    passDone,
    input  logic                    donePassFine,
    output sifhPkg::windowSet_t     windows,
    output sifhPkg::resultSet_t     results,
    output logic                    resultValid
);

    logic [sifhPkg::PIXEL_NUM-1:0][sifhPkg::SAMPLE_W-1:0] centre;
    sifhPkg::windowSet_t    winHold;    // Bases used for the fine result
    logic                   winOk;

    // **************************************************
    // Window rule, live from the held peaks
    always_comb begin
        winOk = 1'b1;
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            centre[p] = {peaks.bin[p], {(sifhPkg::SAMPLE_W-sifhPkg::BIN_W){1'b0}}};
            if (centre[p] < sifhPkg::HALF_WIN) begin
                windows.lower[p] = '0;                      // Bottom edge
            end else begin
                windows.lower[p] = centre[p] - sifhPkg::HALF_WIN;
            end
            if (windows.lower[p] > sifhPkg::WIN_MAX_LOWER) begin
                windows.lower[p] = sifhPkg::WIN_MAX_LOWER;  // Top edge
            end
            // Window still covers the coarse centre
            winOk = winOk && (centre[p] >= windows.lower[p]) &&
                    (centre[p] - windows.lower[p] <= sifhPkg::HALF_WIN);
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winHold     <= '0;
            results     <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= passDone && donePassFine;
            if (passDone && !donePassFine) begin
                winHold <= windows;                         // Coarse pass done
            end
            if (passDone && donePassFine) begin
                for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                    results.peakTime[p] <= winHold.lower[p] +
                        {{(sifhPkg::SAMPLE_W-sifhPkg::BIN_W){1'b0}}, peaks.bin[p]};
                end
            end
        end
    end

    windowInRange: assert property (@(posedge clk) disable iff (!combin_res) winOk);

endmodule

`default_nettype wire

// ==== list.f ====
hdl/sifhPkg.sv
hdl/frameSequencer.sv
hdl/dataFilter.sv
hdl/histUpdater.sv
hdl/windowCalc.sv
hdl/sifhTop.sv
test/tbSifh.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tbSifh -f list.f -o simSifh > build.log 2>&1 \
    && ./obj_dir/simSifh > sim.log 2>&1 \
    || { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^test passed$" sim.log && exit 0 || exit 1

// ==== test/sifhCases.txt ====
// One frame per case: 16 samples of acquisition 0, then 16 samples of acquisition 1
// (pixel 0..3, four samples each), then the expected peak times of pixels 0..3, all hex
// Clustered frame
34 35 35 36 82 81 82 84 C7 C6 C7 C8 52 53 52 51
35 33 37 35 82 80 83 82 C7 C7 C5 C9 52 50 52 54   35 82 C7 52
// Peaks at both ends of the sample range
02 03 02 01 FE FD FE FF 0A 0B 0A 0C F2 F3 F2 F1
02 00 02 04 FE F4 FE F6 0A 09 0A 0D F2 F0 F2 F5   02 F4 0A F2
// Window from bin 1, and pixels whose fine pass is all outside the window
10 12 11 10 78 79 7A 7B 05 05 05 05 F8 F9 FA FB
10 13 10 12 7C 7D 7E 7F 05 05 05 05 FC FD FE FF   10 68 05 E8
// Clustered frame with far outliers, same times as the first case
34 35 35 F0 82 81 82 10 C7 C6 C7 20 52 53 52 E0
35 00 37 35 82 FF 83 82 C7 C7 C5 21 52 50 52 01   35 82 C7 52
// Tied coarse and fine bins, first to reach the top count wins
60 21 62 23 40 41 42 43 43 42 41 40 A0 A1 90 91
24 65 26 67 40 41 42 43 40 41 42 43 92 A2 93 A3   21 40 40 90

// ==== test/tbSifh.sv ====
// Testbench for the two-pass histogram peak finder
// Directed frames come from the cases file, random frames from an LCG
// Every frame is streamed twice and each result strobe is checked
`timescale 1ns/1ps
`default_nettype none

module tbSifh;

    localparam int PASS_LEN  = sifhPkg::ACQ_NUM * sifhPkg::PIXEL_NUM * sifhPkg::DATA_NUM;
    localparam int CASE_LEN  = PASS_LEN + sifhPkg::PIXEL_NUM;   // Samples, then expected times
    localparam int NUM_CASES = 5;
    localparam int TIMEOUT   = 200;                             // Cycles per result wait

    logic                           clk;
    logic                           combin_res;
    logic                           sampleValid;
    logic [sifhPkg::SAMPLE_W-1:0]   sample;
    sifhPkg::resultSet_t            results;
    logic                           resultValid;

    logic [sifhPkg::SAMPLE_W-1:0]   caseMem [NUM_CASES*CASE_LEN];
    logic [sifhPkg::SAMPLE_W-1:0]   frame [PASS_LEN];           // Stream order
    sifhPkg::resultSet_t            expRes;
    int                             modelLower [sifhPkg::PIXEL_NUM];
    sifhPkg::resultSet_t            gotQ [$];                   // Captured result strobes
    logic [31:0]                    lcgState;
    int                             errors;
    int                             testsRun;
    int                             testsBad;

    sifhTop u_sifhTop (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sample      (sample),
        .results     (results),
        .resultValid (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // 100 MHz
    end

    // Result monitor
    always @(posedge clk) begin
        if (resultValid) begin
            gotQ.push_back(results);
        end
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // **************************************************
    // Reference model, both passes per pixel
    task automatic refModel();
        int cnt [sifhPkg::BIN_NUM];
        int top;
        int peak;
        int lower;
        int off;
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            lower = 0;
            for (int fine = 0; fine < 2; fine++) begin
                foreach (cnt[b]) begin
                    cnt[b] = 0;
                end
                top  = 0;
                peak = 0;                                       // Empty histogram gives bin 0
                for (int i = 0; i < PASS_LEN; i++) begin
                    if ((i / sifhPkg::DATA_NUM) % sifhPkg::PIXEL_NUM == p) begin
                        if (fine == 0) begin
                            off = int'(frame[i]) / sifhPkg::BIN_NUM;    // Top four bits
                        end else begin
                            off = int'(frame[i]) - lower;               // Offset in window
                        end
                        if (off >= 0 && off < sifhPkg::BIN_NUM) begin
                            cnt[off]++;
                            if (cnt[off] > top) begin                   // Strictly greater
                                top  = cnt[off];
                                peak = off;
                            end
                        end
                    end
                end
                if (fine == 0) begin
                    lower = peak * sifhPkg::BIN_NUM - int'(sifhPkg::HALF_WIN);
                    if (lower < 0) begin
                        lower = 0;
                    end
                    if (lower > int'(sifhPkg::WIN_MAX_LOWER)) begin
                        lower = int'(sifhPkg::WIN_MAX_LOWER);
                    end
                end
            end
            modelLower[p]      = lower;
            expRes.peakTime[p] = 8'(lower + peak);
        end
    endtask

    // Cluster per pixel with a few stray samples
    task automatic makeRandomFrame();
        logic [sifhPkg::SAMPLE_W-1:0] centre [sifhPkg::PIXEL_NUM];
        logic [31:0]                  r;
        int                           p;
        for (int q = 0; q < sifhPkg::PIXEL_NUM; q++) begin
            r         = lcgNext();
            centre[q] = r[23:16];
        end
        for (int i = 0; i < PASS_LEN; i++) begin
            p = (i / sifhPkg::DATA_NUM) % sifhPkg::PIXEL_NUM;
            r = lcgNext();
            if (r[19:17] == 3'd0) begin
                frame[i] = r[31:24];                            // Outlier
            end else begin
                frame[i] = centre[p] + {4'd0, r[27:24]} - 8'd8; // Spread of 16
            end
        end
    endtask

    // **************************************************
    // Bus drive, optional random idle gaps before each strobe
    task automatic streamStrobes(input int count, input int gapMax);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            if (gapMax > 0) begin
                r = lcgNext();
                repeat (int'(r[27:24]) % (gapMax + 1)) begin
                    @(posedge clk);
                    sampleValid <= 1'b0;
                end
            end
            @(posedge clk);
            sampleValid <= 1'b1;
            sample      <= frame[i % PASS_LEN];
        end
    endtask

    task automatic idleCycle();
        @(posedge clk);
        sampleValid <= 1'b0;
    endtask

    task automatic waitResults(input int count);
        int cycles;
        cycles = 0;
        while (gotQ.size() < count && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (gotQ.size() < count) begin
            $display("Timeout at %0t: only %0d of %0d result strobes arrived",
                     $time, gotQ.size(), count);
            errors++;
        end
    endtask

    // Late or extra strobes would land in this drain
    task automatic checkStrobeCount(input int count);
        repeat (8) @(negedge clk);
        if (gotQ.size() != count) begin
            $display("Expected %0d result strobes by %0t but saw %0d", count, $time, gotQ.size());
            errors++;
        end
    endtask

    task automatic compareResult(input sifhPkg::resultSet_t got, input sifhPkg::resultSet_t want);
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            if (got.peakTime[p] !== want.peakTime[p]) begin
                $display("Mismatch at %0t: results.peakTime[%0d] = %02h, expected %02h",
                         $time, p, got.peakTime[p], want.peakTime[p]);
                errors++;
            end
        end
    endtask

    task automatic checkWindow(input sifhPkg::resultSet_t got);
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            if (int'(got.peakTime[p]) < modelLower[p] ||
                int'(got.peakTime[p]) > modelLower[p] + 15) begin
                $display("Pixel %0d result %02h lies outside its window starting at %02h",
                         p, got.peakTime[p], modelLower[p]);
                errors++;
            end
        end
    endtask

    task automatic finishTest(input string name, input int errStart);
        testsRun++;
        if (errors != errStart) begin
            testsBad++;
            $display("%s: %0d error(s)", name, errors - errStart);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // **************************************************
    // Test sequences
    task automatic runFileCase(input int idx, input string name);
        int errStart;
        errStart = errors;
        for (int i = 0; i < PASS_LEN; i++) begin
            frame[i] = caseMem[idx*CASE_LEN + i];
        end
        refModel();                                 // Window bounds only
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            expRes.peakTime[p] = caseMem[idx*CASE_LEN + PASS_LEN + p];
        end
        gotQ.delete();
        streamStrobes(2 * PASS_LEN, 0);             // Coarse then fine pass
        idleCycle();
        waitResults(1);
        if (gotQ.size() > 0) begin
            compareResult(gotQ[0], expRes);
            checkWindow(gotQ[0]);
        end
        checkStrobeCount(1);
        finishTest(name, errStart);
    endtask

    task automatic runRandom(input string name, input int frames, input int gapMax);
        sifhPkg::resultSet_t expQ [$];
        int                  errStart;
        errStart = errors;
        gotQ.delete();
        for (int f = 0; f < frames; f++) begin
            makeRandomFrame();
            refModel();
            expQ.push_back(expRes);
            streamStrobes(2 * PASS_LEN, gapMax);    // Next frame follows at once
        end
        idleCycle();
        waitResults(frames);
        for (int f = 0; f < frames && f < gotQ.size(); f++) begin
            compareResult(gotQ[f], expQ[f]);
        end
        checkStrobeCount(frames);
        finishTest(name, errStart);
    endtask

    task automatic runResetMidPass();
        int errStart;
        errStart = errors;
        gotQ.delete();
        makeRandomFrame();
        streamStrobes(PASS_LEN + PASS_LEN / 2, 0);  // Stop halfway through the fine pass
        @(posedge clk);
        sampleValid <= 1'b0;
        combin_res  <= 1'b0;
        repeat (3) @(posedge clk);
        combin_res  <= 1'b1;
        makeRandomFrame();
        refModel();
        streamStrobes(2 * PASS_LEN, 0);
        idleCycle();
        @(negedge clk);
        if (gotQ.size() != 0) begin
            $display("Stale result strobe seen before the frame after reset completed");
            errors++;
        end
        waitResults(1);
        if (gotQ.size() > 0) begin
            compareResult(gotQ[0], expRes);
        end
        checkStrobeCount(1);
        finishTest("reset in the fine pass", errStart);
    endtask

    initial begin
        combin_res  = 1'b0;
        sampleValid = 1'b0;
        sample      = '0;
        lcgState    = 32'd76935;
        errors      = 0;
        testsRun    = 0;
        testsBad    = 0;
        $readmemh("test/sifhCases.txt", caseMem);
        repeat (3) @(posedge clk);
        combin_res <= 1'b1;
        @(negedge clk);
        runFileCase(0, "clustered frame");
        runFileCase(1, "peaks near 0 and 255");
        runFileCase(2, "bin 1 edge and empty windows");
        runFileCase(3, "outliers around clusters");
        runFileCase(4, "tied bins");
        runRandom("random frames back to back", 4, 0);
        runRandom("random frames with idle gaps", 4, 3);
        runResetMidPass();
        $display("tests %0d, tests with errors %0d, errors %0d", testsRun, testsBad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
